/* rtl/isa_pkg.sv */
`default_nettype none

package isa_pkg;

	// data width, fixed by the base isa
	localparam int XLEN = 32;

	typedef logic [4:0] reg_idx_t;

	// major opcodes handled by this core
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

	// funct3 for the integer arithmetic group
	localparam logic [2:0] F3_ADD  = 3'b000;
	localparam logic [2:0] F3_SLL  = 3'b001;
	localparam logic [2:0] F3_SLT  = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR  = 3'b100;
	localparam logic [2:0] F3_SR   = 3'b101;
	localparam logic [2:0] F3_OR   = 3'b110;
	localparam logic [2:0] F3_AND  = 3'b111;

	// picks sub over add and sra over srl
	localparam logic [6:0] FUNCT7_ALT = 7'b0100000;

	// register-register format
	typedef struct packed {
		logic [6:0] funct7;
		reg_idx_t   rs2;
		reg_idx_t   rs1;
		logic [2:0] funct3;
		reg_idx_t   rd;
		logic [6:0] opcode;
	} rv_r_t;

	// register-immediate format, shamt sits in the low imm bits
	typedef struct packed {
		logic [11:0] imm12;
		reg_idx_t    rs1;
		logic [2:0]  funct3;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} rv_i_t;

	// upper-immediate format for lui and auipc
	typedef struct packed {
		logic [19:0] imm20;
		reg_idx_t    rd;
		logic [6:0]  opcode;
	} rv_u_t;

	// one instruction word, three ways of reading it
	typedef union packed {
		rv_r_t r;
		rv_i_t i;
		rv_u_t u;
	} rv_inst_u;

endpackage

`default_nettype wire

/* rtl/exe_pkg.sv */
`default_nettype none

package exe_pkg;

	import isa_pkg::*;

	// alu operation codes
	typedef enum logic [3:0] {
		ALU_ADD   = 4'b0000,
		ALU_SUB   = 4'b0001,
		ALU_SLL   = 4'b0010,
		ALU_SLT   = 4'b0011,
		ALU_SLTU  = 4'b0100,
		ALU_XOR   = 4'b0101,
		ALU_SRL   = 4'b0110,
		ALU_SRA   = 4'b0111,
		ALU_OR    = 4'b1000,
		ALU_AND   = 4'b1001,
		ALU_PASS2 = 4'b1010
	} alu_op_e;

	// first alu operand source
	typedef enum logic [1:0] {
		S1_ZERO = 2'b00,
		S1_REG  = 2'b01,
		S1_PC   = 2'b10
	} src1_sel_e;

	// second alu operand source
	typedef enum logic [1:0] {
		S2_REG  = 2'b00,
		S2_IMM  = 2'b01,
		S2_PC   = 2'b10,
		S2_ZERO = 2'b11
	} src2_sel_e;

	// decode to execute
	typedef struct packed {
		logic            valid;
		alu_op_e         alu_op;
		src1_sel_e       src1_sel;
		src2_sel_e       src2_sel;
		reg_idx_t        rs1;
		reg_idx_t        rs2;
		logic [XLEN-1:0] reg1;
		logic [XLEN-1:0] reg2;
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] pc;
		logic            wd;
		reg_idx_t        wreg;
	} id_bundle_t;

	// execute result, also the register file write port
	typedef struct packed {
		logic            valid;
		logic            wd;
		reg_idx_t        wreg;
		logic [XLEN-1:0] wdata;
	} wb_t;

endpackage

`default_nettype wire

/* rtl/alu.sv */
`timescale 1ns/10ps
`default_nettype none

module alu
	import isa_pkg::*;
	import exe_pkg::*;
(
	input  logic [XLEN-1:0] src1_i,
	input  logic [XLEN-1:0] src2_i,
	input  alu_op_e         alu_op_i,
	output logic [XLEN-1:0] result_o
);

	// shift amount is the low five bits only
	logic [4:0] shamt;

	assign shamt = src2_i[4:0];

	always_comb begin
		case (alu_op_i)
			ALU_ADD:
				result_o = src1_i + src2_i;
			ALU_SUB:
				result_o = src1_i - src2_i;
			ALU_SLL:
				result_o = src1_i << shamt;
			// compares give a single bit, zero extended
			ALU_SLT:
				result_o = {{(XLEN-1){1'b0}}, $signed(src1_i) < $signed(src2_i)};
			ALU_SLTU:
				result_o = {{(XLEN-1){1'b0}}, src1_i < src2_i};
			ALU_XOR:
				result_o = src1_i ^ src2_i;
			ALU_SRL:
				result_o = src1_i >> shamt;
			// sign bit fills from the left
			ALU_SRA:
				result_o = $unsigned($signed(src1_i) >>> shamt);
			ALU_OR:
				result_o = src1_i | src2_i;
			ALU_AND:
				result_o = src1_i & src2_i;
			// lui path, src2 is already the upper immediate
			ALU_PASS2:
				result_o = src2_i;
			default:
				result_o = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

module reg_file
	import isa_pkg::*;
	import exe_pkg::*;
(
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  reg_idx_t        rs1_i,
	input  reg_idx_t        rs2_i,
	output logic [XLEN-1:0] rdata1_o,
	output logic [XLEN-1:0] rdata2_o,
	input  wb_t             wb_i
);

	// x0 has no storage
	logic [XLEN-1:0] regs [31:1];
	logic            we;

	// write only real results to a nonzero index
	assign we = wb_i.valid && wb_i.wd && (wb_i.wreg != '0);

	// one read port, new data wins on a same-cycle write
	function automatic logic [XLEN-1:0] read_port(input reg_idx_t idx);
		if (idx == '0)
			return '0;
		else if (we && (idx == wb_i.wreg))
			return wb_i.wdata;
		else
			return regs[idx];
	endfunction

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int k = 1; k < 32; k++)
				regs[k] <= '0;
		end else if (we) begin
			regs[wb_i.wreg] <= wb_i.wdata;
		end
	end

	always_comb begin
		rdata1_o = read_port(rs1_i);
		rdata2_o = read_port(rs2_i);
	end

endmodule

`default_nettype wire

/* rtl/inst_decode.sv */
`timescale 1ns/10ps
`default_nettype none

module inst_decode
	import isa_pkg::*;
	import exe_pkg::*;
(
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic            inst_valid_i,
	input  rv_inst_u        inst_i,
	input  logic [XLEN-1:0] pc_i,
	output reg_idx_t        rs1_o,
	output reg_idx_t        rs2_o,
	input  logic [XLEN-1:0] rdata1_i,
	input  logic [XLEN-1:0] rdata2_i,
	output id_bundle_t      id_o
);

	alu_op_e         dec_op;
	src1_sel_e       dec_s1;
	src2_sel_e       dec_s2;
	logic [XLEN-1:0] dec_imm;
	logic            dec_wd;
	reg_idx_t        dec_rs1;
	reg_idx_t        dec_rs2;
	id_bundle_t      id_q;

	// funct3 to alu op, sub only exists in the register form
	function automatic alu_op_e f3_to_op(input logic [2:0] f3, input logic alt,
		input logic sub_ok);
		case (f3)
			F3_ADD:  return (alt && sub_ok) ? ALU_SUB : ALU_ADD;
			F3_SLL:  return ALU_SLL;
			F3_SLT:  return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR:  return ALU_XOR;
			F3_SR:   return alt ? ALU_SRA : ALU_SRL;
			F3_OR:   return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		// defaults describe an unknown opcode, no write
		dec_op  = ALU_ADD;
		dec_s1  = S1_ZERO;
		dec_s2  = S2_ZERO;
		dec_imm = '0;
		dec_wd  = 1'b0;
		dec_rs1 = '0;
		dec_rs2 = '0;
		case (inst_i.r.opcode)
			OPC_OP: begin
				dec_op  = f3_to_op(inst_i.r.funct3, inst_i.r.funct7 == FUNCT7_ALT, 1'b1);
				dec_s1  = S1_REG;
				dec_s2  = S2_REG;
				dec_rs1 = inst_i.r.rs1;
				dec_rs2 = inst_i.r.rs2;
				dec_wd  = 1'b1;
			end
			OPC_OP_IMM: begin
				// top imm bits act as funct7 for srli / srai
				dec_op  = f3_to_op(inst_i.i.funct3, inst_i.i.imm12[11:5] == FUNCT7_ALT, 1'b0);
				dec_s1  = S1_REG;
				dec_s2  = S2_IMM;
				dec_imm = {{(XLEN-12){inst_i.i.imm12[11]}}, inst_i.i.imm12};
				dec_rs1 = inst_i.i.rs1;
				dec_wd  = 1'b1;
			end
			OPC_LUI: begin
				dec_op  = ALU_PASS2;
				dec_s2  = S2_IMM;
				dec_imm = {inst_i.u.imm20, 12'b0};
				dec_wd  = 1'b1;
			end
			OPC_AUIPC: begin
				dec_s1  = S1_PC;
				dec_s2  = S2_IMM;
				dec_imm = {inst_i.u.imm20, 12'b0};
				dec_wd  = 1'b1;
			end
			default: ;
		endcase
	end

	// register file read addresses, data comes back this cycle
	assign rs1_o = dec_rs1;
	assign rs2_o = dec_rs2;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			id_q <= '0;
		end else begin
			id_q.valid <= inst_valid_i;
			// hold the payload between strobes
			if (inst_valid_i) begin
				id_q.alu_op   <= dec_op;
				id_q.src1_sel <= dec_s1;
				id_q.src2_sel <= dec_s2;
				id_q.rs1      <= dec_rs1;
				id_q.rs2      <= dec_rs2;
				id_q.reg1     <= rdata1_i;
				id_q.reg2     <= rdata2_i;
				id_q.imm      <= dec_imm;
				id_q.pc       <= pc_i;
				id_q.wd       <= dec_wd;
				id_q.wreg     <= inst_i.r.rd;
			end
		end
	end

	assign id_o = id_q;

endmodule

`default_nettype wire

/* rtl/exe_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_stage
	import isa_pkg::*;
	import exe_pkg::*;
(
	input  logic       clk_i,
	input  logic       arst_n_i,
	input  id_bundle_t id_i,
	output wb_t        wb_o
);

	wb_t             wb_q;
	logic            fwd_ok;
	logic [XLEN-1:0] reg1;
	logic [XLEN-1:0] reg2;
	logic [XLEN-1:0] src1;
	logic [XLEN-1:0] src2;
	logic [XLEN-1:0] result;

	// held writeback is a live register write
	assign fwd_ok = wb_q.valid && wb_q.wd && (wb_q.wreg != '0);

	// bypass from the previous instruction on an index match
	assign reg1 = (fwd_ok && (wb_q.wreg == id_i.rs1)) ? wb_q.wdata : id_i.reg1;
	assign reg2 = (fwd_ok && (wb_q.wreg == id_i.rs2)) ? wb_q.wdata : id_i.reg2;

	always_comb begin
		case (id_i.src1_sel)
			S1_REG:  src1 = reg1;
			S1_PC:   src1 = id_i.pc;
			default: src1 = '0;
		endcase
		case (id_i.src2_sel)
			S2_REG:  src2 = reg2;
			S2_IMM:  src2 = id_i.imm;
			S2_PC:   src2 = id_i.pc;
			default: src2 = '0;
		endcase
	end

	alu i_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.alu_op_i (id_i.alu_op),
		.result_o (result)
	);

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_q <= '0;
		end else begin
			wb_q.valid <= id_i.valid;
			// a bubble must not look like a write
			wb_q.wd    <= id_i.valid && id_i.wd;
			wb_q.wreg  <= id_i.wreg;
			wb_q.wdata <= result;
		end
	end

	assign wb_o = wb_q;

endmodule

`default_nettype wire

/* rtl/exe_core.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_core
	import isa_pkg::*;
	import exe_pkg::*;
(
	input  logic            clk_i,
	input  logic            arst_n_i,
	input  logic            inst_valid_i,
	input  rv_inst_u        inst_i,
	input  logic [XLEN-1:0] pc_i,
	output wb_t             wb_o
);

	reg_idx_t        rs1;
	reg_idx_t        rs2;
	logic [XLEN-1:0] rdata1;
	logic [XLEN-1:0] rdata2;
	id_bundle_t      id_bundle;
	// one writeback feeds both the register file and the output
	wb_t             wb;

	inst_decode i_inst_decode (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.rs1_o        (rs1),
		.rs2_o        (rs2),
		.rdata1_i     (rdata1),
		.rdata2_i     (rdata2),
		.id_o         (id_bundle)
	);

	reg_file i_reg_file (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wb_i     (wb)
	);

	exe_stage i_exe_stage (
		.clk_i    (clk_i),
		.arst_n_i (arst_n_i),
		.id_i     (id_bundle),
		.wb_o     (wb)
	);

	assign wb_o = wb;

endmodule

`default_nettype wire

/* sim/exe_core_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module exe_core_tb
	import isa_pkg::*;
	import exe_pkg::*;
();

	logic            clk_i = 1'b0;
	logic            arst_n_i;
	logic            inst_valid_i;
	rv_inst_u        inst_i;
	logic [XLEN-1:0] pc_i;
	wb_t             wb_o;

	// reference architectural state
	logic [XLEN-1:0] model_regs [32];
	// expected writebacks and the negedge count they are due at
	wb_t             exp_q [$];
	int unsigned     due_q [$];
	int unsigned     ncyc = 0;
	string           test_name = "reset";

	exe_core i_exe_core (
		.clk_i        (clk_i),
		.arst_n_i     (arst_n_i),
		.inst_valid_i (inst_valid_i),
		.inst_i       (inst_i),
		.pc_i         (pc_i),
		.wb_o         (wb_o)
	);

	// 4 ns period
	always #2 clk_i = ~clk_i;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_wb(input string name, input wb_t exp, input wb_t act);
		wb_t want;
		want = exp;
		// strobes without a write carry no meaningful data
		if (!exp.wd)
			want.wdata = act.wdata;
		if (act !== want)
			abort_run($sformatf("FAILED %s expected %h actual %h", name, want, act));
	endtask

	task automatic check_idle(input string name, input wb_t act);
		if (act.valid !== 1'b0)
			abort_run($sformatf("FAILED %s wb valid expected 0 actual %b", name, act.valid));
	endtask

	// instruction encoders
	function automatic rv_inst_u enc_r(input logic [6:0] f7, input reg_idx_t rs2,
		input reg_idx_t rs1, input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
		rv_inst_u w;
		w = {f7, rs2, rs1, f3, rd, opc};
		return w;
	endfunction

	function automatic rv_inst_u enc_i(input logic [11:0] imm, input reg_idx_t rs1,
		input logic [2:0] f3, input reg_idx_t rd, input logic [6:0] opc);
		rv_inst_u w;
		w = {imm, rs1, f3, rd, opc};
		return w;
	endfunction

	function automatic rv_inst_u enc_u(input logic [19:0] imm, input reg_idx_t rd,
		input logic [6:0] opc);
		rv_inst_u w;
		w = {imm, rd, opc};
		return w;
	endfunction

	// isa reference model updating the registers in issue order
	function automatic wb_t model_exec(input rv_inst_u inst, input logic [XLEN-1:0] pc);
		wb_t             r;
		logic [XLEN-1:0] a;
		logic [XLEN-1:0] b;
		logic [4:0]      sh;
		logic            alt;
		r.valid = 1'b1;
		r.wd    = 1'b1;
		r.wreg  = inst.r.rd;
		r.wdata = '0;
		a       = model_regs[inst.r.rs1];
		alt     = (inst.r.funct7 == FUNCT7_ALT);
		if (inst.r.opcode == OPC_OP)
			b = model_regs[inst.r.rs2];
		else
			b = {{20{inst.i.imm12[11]}}, inst.i.imm12};
		sh = b[4:0];
		case (inst.r.opcode)
			OPC_OP, OPC_OP_IMM: begin
				case (inst.r.funct3)
					// sub exists only in the register form
					F3_ADD:  r.wdata = (inst.r.opcode == OPC_OP && alt) ? a - b : a + b;
					F3_SLL:  r.wdata = a << sh;
					F3_SLT:  r.wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					F3_SLTU: r.wdata = (a < b) ? 32'd1 : 32'd0;
					F3_XOR:  r.wdata = a ^ b;
					// arithmetic shift as inverted logical shift of the inverse
					F3_SR:   r.wdata = (alt && a[31]) ? ~(~a >> sh) : a >> sh;
					F3_OR:   r.wdata = a | b;
					default: r.wdata = a & b;
				endcase
			end
			OPC_LUI:   r.wdata = {inst.u.imm20, 12'h000};
			OPC_AUIPC: r.wdata = pc + {inst.u.imm20, 12'h000};
			default:   r.wd = 1'b0;
		endcase
		if (r.wd && r.wreg != 5'd0)
			model_regs[r.wreg] = r.wdata;
		return r;
	endfunction

	// random operand words with extremes mixed in
	function automatic logic [XLEN-1:0] rand_word();
		case ($urandom % 8)
			0: return 32'h0000_0000;
			1: return 32'hffff_ffff;
			2: return 32'h8000_0000;
			3: return 32'h7fff_ffff;
			4: return $urandom % 32;
			default: return $urandom;
		endcase
	endfunction

	function automatic logic [11:0] rand_imm12();
		logic [31:0] v;
		v = $urandom;
		case ($urandom % 6)
			0: return 12'h000;
			1: return 12'h7ff;
			2: return 12'h800;
			3: return 12'hfff;
			default: return v[11:0];
		endcase
	endfunction

	function automatic logic [4:0] rand_shamt();
		logic [31:0] v;
		v = $urandom;
		case ($urandom % 4)
			0: return 5'd0;
			1: return 5'd31;
			default: return v[4:0];
		endcase
	endfunction

	function automatic logic [XLEN-1:0] rand_pc();
		logic [31:0] v;
		v = $urandom;
		return {v[31:2], 2'b00};
	endfunction

	// random OP or OP-IMM with a legal funct7
	function automatic rv_inst_u rand_arith(input reg_idx_t rd, input reg_idx_t rs1,
		input reg_idx_t rs2);
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm;
		f3  = $urandom % 8;
		alt = $urandom % 2;
		if ($urandom % 2)
			return enc_r((alt && (f3 == F3_ADD || f3 == F3_SR)) ? FUNCT7_ALT : 7'h00,
				rs2, rs1, f3, rd, OPC_OP);
		imm = rand_imm12();
		// shift immediates keep funct7 in the top bits
		if (f3 == F3_SLL || f3 == F3_SR)
			imm = {(alt && f3 == F3_SR) ? FUNCT7_ALT : 7'h00, rand_shamt()};
		return enc_i(imm, rs1, f3, rd, OPC_OP_IMM);
	endfunction

	// one strobe with its result due at the negedge after the third edge
	task automatic issue(input rv_inst_u inst, input logic [XLEN-1:0] pc);
		@(posedge clk_i);
		inst_valid_i <= 1'b1;
		inst_i       <= inst;
		pc_i         <= pc;
		exp_q.push_back(model_exec(inst, pc));
		due_q.push_back(ncyc + 3);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk_i);
			inst_valid_i <= 1'b0;
		end
	endtask

	task automatic drain(input string what);
		int waited;
		waited = 0;
		idle(1);
		while (exp_q.size() != 0) begin
			if (waited == 10) begin
				abort_run($sformatf("timeout: writeback strobe for %s never came", what));
			end else begin
				@(posedge clk_i);
				waited++;
			end
		end
	endtask

	task automatic load_reg(input reg_idx_t idx, input logic [XLEN-1:0] val);
		logic [19:0] hi;
		// round up so the signed low part lands on val
		hi = val[31:12] + {19'b0, val[11]};
		issue(enc_u(hi, idx, OPC_LUI), rand_pc());
		issue(enc_i(val[11:0], idx, F3_ADD, idx, OPC_OP_IMM), rand_pc());
	endtask

	// addi x0 with imm zero exposes a register on wdata
	task automatic read_all();
		for (int k = 1; k < 32; k++)
			issue(enc_i(12'h000, reg_idx_t'(k), F3_ADD, 5'd0, OPC_OP_IMM), rand_pc());
	endtask

	// writeback monitor sampling mid-cycle
	always @(negedge clk_i) begin
		ncyc++;
		if (exp_q.size() == 0) begin
			check_idle(test_name, wb_o);
		end else if (wb_o.valid) begin
			if (due_q[0] != ncyc) begin
				abort_run($sformatf("FAILED %s latency expected cycle %0d actual cycle %0d",
					test_name, due_q[0], ncyc));
			end else begin
				check_wb(test_name, exp_q.pop_front(), wb_o);
				void'(due_q.pop_front());
			end
		end else if (ncyc >= due_q[0]) begin
			abort_run($sformatf("%s: writeback strobe missing at its cycle", test_name));
		end
	end

	initial begin
		reg_idx_t    rd;
		reg_idx_t    r1;
		reg_idx_t    r2;
		reg_idx_t    recent [3];
		logic [6:0]  opc;
		logic [31:0] v;
		arst_n_i     = 1'b0;
		inst_valid_i = 1'b0;
		inst_i       = '0;
		pc_i         = '0;
		for (int k = 0; k < 32; k++)
			model_regs[k] = '0;
		void'($urandom(71));
		repeat (16) @(posedge clk_i);
		arst_n_i <= 1'b1;

		// quiet output and then every register reads zero
		test_name = "reset_state";
		idle(20);
		read_all();
		drain(test_name);

		test_name = "latency_order";
		for (int n = 0; n < 30; n++) begin
			issue(enc_i(rand_imm12(), $urandom % 32, F3_ADD, $urandom % 32, OPC_OP_IMM),
				rand_pc());
			idle(1 + $urandom % 6);
		end
		drain(test_name);

		test_name = "random_arith";
		for (int n = 0; n < 200; n++) begin
			r1 = 1 + $urandom % 31;
			r2 = 1 + $urandom % 31;
			load_reg(r1, rand_word());
			load_reg(r2, rand_word());
			// rd may be x0
			issue(rand_arith($urandom % 32, r1, r2), rand_pc());
			idle($urandom % 3);
		end
		drain(test_name);

		// one strobe per cycle with sources from the last three destinations
		test_name = "back_to_back";
		recent[0] = 5'd1;
		recent[1] = 5'd2;
		recent[2] = 5'd3;
		for (int n = 0; n < 150; n++) begin
			rd = $urandom % 32;
			issue(rand_arith(rd, recent[$urandom % 3], recent[$urandom % 3]), rand_pc());
			recent[2] = recent[1];
			recent[1] = recent[0];
			recent[0] = rd;
		end
		drain(test_name);

		test_name = "upper_imm";
		for (int n = 0; n < 60; n++) begin
			v = rand_word();
			opc = ($urandom % 2) ? OPC_LUI : OPC_AUIPC;
			issue(enc_u(v[31:12], $urandom % 32, opc), rand_pc());
			idle($urandom % 2);
		end
		drain(test_name);

		test_name = "unknown_opcode";
		for (int n = 0; n < 40; n++) begin
			v = $urandom;
			opc = v[6:0];
			// kept opcodes all have bit 6 clear
			if (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_LUI || opc == OPC_AUIPC)
				opc[6] = 1'b1;
			issue(rv_inst_u'({v[31:7], opc}), rand_pc());
		end
		read_all();
		drain(test_name);

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
rtl/isa_pkg.sv
rtl/exe_pkg.sv
rtl/alu.sv
rtl/reg_file.sv
rtl/inst_decode.sv
rtl/exe_stage.sv
rtl/exe_core.sv
sim/exe_core_tb.sv
